/* verilog/brb_cfg.svh */
`ifndef BRB_CFG_SVH
`define BRB_CFG_SVH

// ==================================================
// Buffer geometry
// ==================================================

// Number of branch slots in the ring
`define BRB_DEPTH 16

// Push, execute and resolve width of the core
`define BRB_LANES 3

// Branch tag and target widths
`define BRB_ROB_ID_W 6
`define BRB_PC_W 32

`endif

/* verilog/brb_tag_pkg.sv */
`include "brb_cfg.svh"

// Types describing a single branch in flight
package brb_tag_pkg;

    // ROB ID carried by every branch, used as the match key
    typedef logic [`BRB_ROB_ID_W-1:0] rob_id_t;

    // Redirect target reported by execute
    typedef logic [`BRB_PC_W-1:0] pc_t;

    // Lane number or lane offset within a group of three
    typedef logic [1:0] lane_t;

endpackage

/* verilog/brb_ptr_pkg.sv */
`include "brb_cfg.svh"

// Types describing a position inside the ring
package brb_ptr_pkg;

    // Physical slot number
    typedef logic [$clog2(`BRB_DEPTH)-1:0] slot_idx_t;

    // Slot number plus wrap bit, full and empty differ only in the top bit
    typedef logic [$clog2(`BRB_DEPTH):0] ptr_t;

    // Occupancy, 0 up to the full depth
    typedef logic [$clog2(`BRB_DEPTH):0] count_t;

endpackage

/* verilog/brb_alloc.sv */
`include "brb_cfg.svh"

module brb_alloc
    import brb_tag_pkg::*, brb_ptr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Decode push lanes
    input  logic [`BRB_LANES-1:0] push_en,
    input  rob_id_t               push_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0] push_is_jalr,
    // From the resolver
    input  ptr_t                  head_ptr,
    input  count_t                pop_count,
    input  logic                  flush,
    // Write port into the slots
    output logic [`BRB_DEPTH-1:0] slot_wr_en,
    output rob_id_t               slot_wr_rob_id [`BRB_DEPTH],
    output logic [`BRB_DEPTH-1:0] slot_wr_is_jalr,
    // Status
    output count_t                buffer_count,
    output logic                  buffer_empty,
    output logic                  buffer_full
);

    ptr_t      tail_ptr;
    count_t    push_num;
    logic      push_ok;
    slot_idx_t lane_slot [`BRB_LANES];

    // ==================================================
    // Occupancy
    // ==================================================

    // Wrap bit makes the difference exact for 0..16
    assign buffer_count = tail_ptr - head_ptr;
    assign buffer_empty = (buffer_count == '0);
    assign buffer_full  = (buffer_count == count_t'(`BRB_DEPTH));

    // Each set lane takes the next slot after the lanes below it
    always_comb begin
        lane_t off;
        off      = '0;
        push_num = '0;
        for (int l = 0; l < `BRB_LANES; l++) begin
            lane_slot[l] = slot_idx_t'(tail_ptr) + slot_idx_t'(off);
            off          = off + lane_t'(push_en[l]);
            push_num     = push_num + count_t'(push_en[l]);
        end
    end

    // Whole group or nothing
    // Slots popped this cycle already count as free
    assign push_ok = !flush &&
                     (push_num <= count_t'(`BRB_DEPTH) - buffer_count + pop_count);

    // Per-slot write enable and data
    always_comb begin
        slot_wr_en      = '0;
        slot_wr_is_jalr = '0;
        for (int s = 0; s < `BRB_DEPTH; s++) begin
            slot_wr_rob_id[s] = '0;
        end
        for (int l = 0; l < `BRB_LANES; l++) begin
            if (push_ok && push_en[l]) begin
                slot_wr_en[lane_slot[l]]      = 1'b1;
                slot_wr_rob_id[lane_slot[l]]  = push_rob_id[l];
                slot_wr_is_jalr[lane_slot[l]] = push_is_jalr[l];
            end
        end
    end

    // Tail returns to zero together with the head on a flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
        end else if (push_ok) begin
            tail_ptr <= tail_ptr + push_num;
        end
    end

endmodule

/* verilog/brb_slot.sv */
`include "brb_cfg.svh"

module brb_slot
    import brb_tag_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Load from the allocator
    input  logic                  wr_en,
    input  rob_id_t               wr_rob_id,
    input  logic                  wr_is_jalr,
    // Retire and flush from the resolver
    input  logic                  release_en,
    input  logic                  flush,
    // Execute result lanes
    input  logic [`BRB_LANES-1:0] exec_valid,
    input  rob_id_t               exec_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0] exec_mispredicted,
    input  pc_t                   exec_correct_pc [`BRB_LANES],
    // Entry state
    output logic                  valid,
    output rob_id_t               rob_id,
    output logic                  is_jalr,
    // Stored result merged with the live strobe
    output logic                  eff_resolved,
    output logic                  eff_mispredicted,
    output pc_t                   eff_correct_pc
);

    logic                  res_q;
    logic                  mis_q;
    pc_t                   cpc_q;
    logic [`BRB_LANES-1:0] hit;
    logic                  hit_any;
    logic                  hit_mis;
    pc_t                   hit_pc;

    // ==================================================
    // Execute match
    // ==================================================

    // Stale tags never match once the slot is invalid
    always_comb begin
        hit_mis = 1'b0;
        hit_pc  = '0;
        for (int l = 0; l < `BRB_LANES; l++) begin
            hit[l] = valid && exec_valid[l] && (exec_rob_id[l] == rob_id);
        end
        // Walk down so lane 0 is applied last and wins
        for (int l = `BRB_LANES - 1; l >= 0; l--) begin
            if (hit[l]) begin
                hit_mis = exec_mispredicted[l];
                hit_pc  = exec_correct_pc[l];
            end
        end
    end

    assign hit_any = |hit;

    // Bypass: the live strobe beats the stored copy
    assign eff_resolved     = res_q || hit_any;
    assign eff_mispredicted = hit_any ? hit_mis : mis_q;
    assign eff_correct_pc   = hit_any ? hit_pc : cpc_q;

    // ==================================================
    // State
    // ==================================================

    // A write beats a release, the ring may reuse a slot as it drains
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            res_q <= 1'b0;
            mis_q <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
            res_q <= 1'b0;
            mis_q <= 1'b0;
        end else if (wr_en) begin
            valid <= 1'b1;
            res_q <= 1'b0;
            mis_q <= 1'b0;
        end else if (release_en) begin
            valid <= 1'b0;
            res_q <= 1'b0;
        end else if (hit_any) begin
            res_q <= 1'b1;
            mis_q <= hit_mis;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            rob_id  <= wr_rob_id;
            is_jalr <= wr_is_jalr;
        end
        if (hit_any) begin
            cpc_q <= hit_pc;
        end
    end

endmodule

/* verilog/brb_resolve.sv */
`include "brb_cfg.svh"

module brb_resolve
    import brb_tag_pkg::*, brb_ptr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  count_t                buffer_count,
    input  logic                  flush_en,
    // Per-slot state
    input  logic [`BRB_DEPTH-1:0] slot_valid,
    input  rob_id_t               slot_rob_id [`BRB_DEPTH],
    input  logic [`BRB_DEPTH-1:0] slot_is_jalr,
    input  logic [`BRB_DEPTH-1:0] slot_eff_resolved,
    input  logic [`BRB_DEPTH-1:0] slot_eff_mispredicted,
    input  pc_t                   slot_eff_correct_pc [`BRB_DEPTH],
    // Ring control
    output ptr_t                  head_ptr,
    output count_t                pop_count,
    output logic [`BRB_DEPTH-1:0] slot_release,
    output logic                  flush,
    // Resolution lanes, oldest first
    output logic [`BRB_LANES-1:0] resolved,
    output logic [`BRB_LANES-1:0] mispredicted,
    output pc_t                   correct_pc [`BRB_LANES],
    output rob_id_t               resolved_rob_id [`BRB_LANES],
    output logic [`BRB_LANES-1:0] is_jalr
);

    slot_idx_t lane_idx [`BRB_LANES];
    logic      bad_spec;

    // ==================================================
    // In-order selection
    // ==================================================

    // Lane l looks at head + l, the ring index wraps by itself
    always_comb begin
        logic go;
        go           = 1'b1;
        pop_count    = '0;
        slot_release = '0;
        for (int l = 0; l < `BRB_LANES; l++) begin
            lane_idx[l]        = slot_idx_t'(head_ptr) + slot_idx_t'(l);
            // Idle lanes show zero
            resolved[l]        = 1'b0;
            mispredicted[l]    = 1'b0;
            correct_pc[l]      = '0;
            resolved_rob_id[l] = '0;
            is_jalr[l]         = 1'b0;
            if (go && (count_t'(l) < buffer_count) &&
                slot_valid[lane_idx[l]] && slot_eff_resolved[lane_idx[l]]) begin
                resolved[l]        = 1'b1;
                mispredicted[l]    = slot_eff_mispredicted[lane_idx[l]];
                correct_pc[l]      = slot_eff_correct_pc[lane_idx[l]];
                resolved_rob_id[l] = slot_rob_id[lane_idx[l]];
                is_jalr[l]         = slot_is_jalr[lane_idx[l]];
                if (slot_eff_mispredicted[lane_idx[l]]) begin
                    // Younger lanes are wrong path
                    go = 1'b0;
                end else begin
                    pop_count                = pop_count + 1'b1;
                    slot_release[lane_idx[l]] = 1'b1;
                end
            end else begin
                // Oldest unresolved branch blocks the rest
                go = 1'b0;
            end
        end
    end

    // At most one lane can carry a mispredict
    assign bad_spec = |(resolved & mispredicted);
    assign flush    = bad_spec || flush_en;

    // ==================================================
    // Head pointer
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (flush) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + pop_count;
        end
    end

endmodule

/* verilog/branch_resolution_buffer.sv */
`include "brb_cfg.svh"

module branch_resolution_buffer
    import brb_tag_pkg::*, brb_ptr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Decode push
    input  logic [`BRB_LANES-1:0] push_en,
    input  rob_id_t               push_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0] push_is_jalr,
    // Execute results
    input  logic [`BRB_LANES-1:0] exec_valid,
    input  rob_id_t               exec_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0] exec_mispredicted,
    input  pc_t                   exec_correct_pc [`BRB_LANES],
    input  logic                  flush_en,
    // Resolution
    output logic [`BRB_LANES-1:0] resolved,
    output logic [`BRB_LANES-1:0] mispredicted,
    output pc_t                   correct_pc [`BRB_LANES],
    output rob_id_t               resolved_rob_id [`BRB_LANES],
    output logic [`BRB_LANES-1:0] is_jalr,
    // Status
    output logic                  buffer_empty,
    output logic                  buffer_full,
    output count_t                buffer_count
);

    ptr_t                  head_ptr;
    count_t                pop_count;
    logic                  flush;
    logic [`BRB_DEPTH-1:0] slot_wr_en;
    rob_id_t               slot_wr_rob_id [`BRB_DEPTH];
    logic [`BRB_DEPTH-1:0] slot_wr_is_jalr;
    logic [`BRB_DEPTH-1:0] slot_release;
    logic [`BRB_DEPTH-1:0] slot_valid;
    rob_id_t               slot_rob_id [`BRB_DEPTH];
    logic [`BRB_DEPTH-1:0] slot_is_jalr;
    logic [`BRB_DEPTH-1:0] slot_eff_resolved;
    logic [`BRB_DEPTH-1:0] slot_eff_mispredicted;
    pc_t                   slot_eff_correct_pc [`BRB_DEPTH];

    // Tail side
    brb_alloc i_alloc (
        .clk, .rst_n, .push_en, .push_rob_id, .push_is_jalr,
        .head_ptr, .pop_count, .flush,
        .slot_wr_en, .slot_wr_rob_id, .slot_wr_is_jalr,
        .buffer_count, .buffer_empty, .buffer_full
    );

    // One entry per ring position
    for (genvar s = 0; s < `BRB_DEPTH; s++) begin : g_slot
        brb_slot i_slot (
            .clk, .rst_n,
            .wr_en            (slot_wr_en[s]),
            .wr_rob_id        (slot_wr_rob_id[s]),
            .wr_is_jalr       (slot_wr_is_jalr[s]),
            .release_en       (slot_release[s]),
            .flush,
            .exec_valid, .exec_rob_id, .exec_mispredicted, .exec_correct_pc,
            .valid            (slot_valid[s]),
            .rob_id           (slot_rob_id[s]),
            .is_jalr          (slot_is_jalr[s]),
            .eff_resolved     (slot_eff_resolved[s]),
            .eff_mispredicted (slot_eff_mispredicted[s]),
            .eff_correct_pc   (slot_eff_correct_pc[s])
        );
    end

    // Head side
    brb_resolve i_resolve (
        .clk, .rst_n, .buffer_count, .flush_en,
        .slot_valid, .slot_rob_id, .slot_is_jalr,
        .slot_eff_resolved, .slot_eff_mispredicted, .slot_eff_correct_pc,
        .head_ptr, .pop_count, .slot_release, .flush,
        .resolved, .mispredicted, .correct_pc, .resolved_rob_id, .is_jalr
    );

endmodule

/* verification/brb_chk.sv */
`include "brb_cfg.svh"

module brb_chk
    import brb_ptr_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic [`BRB_LANES-1:0] resolved,
    input logic [`BRB_LANES-1:0] mispredicted,
    input logic                  buffer_empty,
    input logic                  buffer_full,
    input count_t                buffer_count
);

    int failures = 0;

    // ==================================================
    // Status and lane ordering
    // ==================================================

    // Full and empty are exclusive
    a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(buffer_full && buffer_empty))
        else begin
            $error("buffer_full and buffer_empty set together");
            failures++;
        end

    // A younger lane resolves only behind a correct older one
    a_lane1_order: assert property (@(posedge clk) disable iff (!rst_n)
        resolved[1] |-> resolved[0] && !mispredicted[0])
        else begin
            $error("lane 1 resolved without a correct lane 0");
            failures++;
        end

    a_lane2_order: assert property (@(posedge clk) disable iff (!rst_n)
        resolved[2] |-> resolved[1] && !mispredicted[1])
        else begin
            $error("lane 2 resolved without a correct lane 1");
            failures++;
        end

    // Occupancy bound
    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        buffer_count <= count_t'(`BRB_DEPTH))
        else begin
            $error("buffer_count above the depth");
            failures++;
        end

endmodule

/* verification/brb_scoreboard.sv */
`include "brb_cfg.svh"

module brb_scoreboard
    import brb_tag_pkg::*, brb_ptr_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    // DUT inputs
    input  logic [`BRB_LANES-1:0]           push_en,
    input  rob_id_t                         push_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0]           push_is_jalr,
    input  logic [`BRB_LANES-1:0]           exec_valid,
    input  rob_id_t                         exec_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0]           exec_mispredicted,
    input  pc_t                             exec_correct_pc [`BRB_LANES],
    input  logic                            flush_en,
    // DUT outputs
    input  logic [`BRB_LANES-1:0]           resolved,
    input  logic [`BRB_LANES-1:0]           mispredicted,
    input  pc_t                             correct_pc [`BRB_LANES],
    input  rob_id_t                         resolved_rob_id [`BRB_LANES],
    input  logic [`BRB_LANES-1:0]           is_jalr,
    input  logic                            buffer_empty,
    input  logic                            buffer_full,
    input  count_t                          buffer_count,
    // Model view for the stimulus
    output logic [(1 << `BRB_ROB_ID_W)-1:0] id_busy,
    output rob_id_t                         live_ids [`BRB_DEPTH],
    output int                              live_num,
    // Totals
    output int                              errors,
    output int                              checks
);

    typedef struct packed {
        rob_id_t id;
        logic    jalr;
        logic    res;
        logic    mis;
        pc_t     pc;
    } entry_t;

    // Oldest entry at index 0
    entry_t q [$];
    int     n_err = 0;
    int     n_chk = 0;

    assign errors = n_err;
    assign checks = n_chk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_chk++;
        if (act !== exp) begin
            n_err++;
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // First matching execute lane counts, lane 0 is checked first
    function automatic entry_t apply_exec(entry_t e);
        for (int l = 0; l < `BRB_LANES; l++) begin
            if (exec_valid[l] && exec_rob_id[l] == e.id) begin
                e.res = 1'b1;
                e.mis = exec_mispredicted[l];
                e.pc  = exec_correct_pc[l];
                return e;
            end
        end
        return e;
    endfunction

    // ==================================================
    // Compare mid-cycle, then step the model
    // ==================================================

    always @(negedge clk) begin
        entry_t                e;
        logic [`BRB_LANES-1:0] exp_res;
        logic [`BRB_LANES-1:0] exp_mis;
        logic [`BRB_LANES-1:0] exp_jalr;
        pc_t                   exp_pc [`BRB_LANES];
        rob_id_t               exp_id [`BRB_LANES];
        logic                  go;
        logic                  kill;
        int                    pop;
        exp_res  = '0;
        exp_mis  = '0;
        exp_jalr = '0;
        go       = 1'b1;
        kill     = flush_en;
        pop      = 0;
        // Oldest three, cut after the first unresolved or mispredicted one
        for (int l = 0; l < `BRB_LANES; l++) begin
            exp_pc[l] = '0;
            exp_id[l] = '0;
            if (go && l < q.size()) begin
                e  = apply_exec(q[l]);
                go = e.res && !e.mis;
                if (e.res) begin
                    exp_res[l]  = 1'b1;
                    exp_mis[l]  = e.mis;
                    exp_pc[l]   = e.pc;
                    exp_id[l]   = e.id;
                    exp_jalr[l] = e.jalr;
                    kill        = kill || e.mis;
                    pop         = pop + (e.mis ? 0 : 1);
                end
            end
        end
        for (int l = 0; l < `BRB_LANES; l++) begin
            check_value($sformatf("resolved[%0d]", l), exp_res[l], resolved[l]);
            check_value($sformatf("mispredicted[%0d]", l), exp_mis[l], mispredicted[l]);
            check_value($sformatf("correct_pc[%0d]", l), exp_pc[l], correct_pc[l]);
            check_value($sformatf("resolved_rob_id[%0d]", l), exp_id[l], resolved_rob_id[l]);
            check_value($sformatf("is_jalr[%0d]", l), exp_jalr[l], is_jalr[l]);
        end
        check_value("buffer_count", 32'(q.size()), buffer_count);
        check_value("buffer_empty", q.size() == 0, buffer_empty);
        check_value("buffer_full", q.size() == `BRB_DEPTH, buffer_full);

        // Next state: flush, then results, pops and a push group that fits
        if (!rst_n || kill) begin
            q.delete();
        end else begin
            for (int i = 0; i < q.size(); i++) begin
                q[i] = apply_exec(q[i]);
            end
            for (int i = 0; i < pop; i++) begin
                q.delete(0);
            end
            if ($countones(push_en) <= `BRB_DEPTH - q.size()) begin
                for (int l = 0; l < `BRB_LANES; l++) begin
                    if (push_en[l]) begin
                        e      = '0;
                        e.id   = push_rob_id[l];
                        e.jalr = push_is_jalr[l];
                        q.push_back(e);
                    end
                end
            end
        end

        // Tags in flight and branches still waiting for execute
        id_busy  = '0;
        live_num = 0;
        for (int i = 0; i < `BRB_DEPTH; i++) begin
            live_ids[i] = '0;
        end
        for (int i = 0; i < q.size(); i++) begin
            id_busy[q[i].id] = 1'b1;
            if (!q[i].res) begin
                live_ids[live_num] = q[i].id;
                live_num++;
            end
        end
    end

endmodule

/* verification/tb_branch_resolution_buffer.sv */
`include "brb_cfg.svh"

module tb_branch_resolution_buffer
    import brb_tag_pkg::*, brb_ptr_pkg::*;
();

    localparam logic [31:0] SEED          = 32'h9ba1_2b9a;
    localparam int          RESET_CYCLES  = 16;
    localparam int          SETTLE_CYCLES = 4;
    localparam int          TEST_CYCLES   = 250;
    // Five random tests plus reset, with slack for the per-test wrap-up
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SETTLE_CYCLES + 5 * TEST_CYCLES + 40;

    logic                            clk;
    logic                            rst_n;
    logic [`BRB_LANES-1:0]           push_en;
    rob_id_t                         push_rob_id [`BRB_LANES];
    logic [`BRB_LANES-1:0]           push_is_jalr;
    logic [`BRB_LANES-1:0]           exec_valid;
    rob_id_t                         exec_rob_id [`BRB_LANES];
    logic [`BRB_LANES-1:0]           exec_mispredicted;
    pc_t                             exec_correct_pc [`BRB_LANES];
    logic                            flush_en;
    logic [`BRB_LANES-1:0]           resolved;
    logic [`BRB_LANES-1:0]           mispredicted;
    pc_t                             correct_pc [`BRB_LANES];
    rob_id_t                         resolved_rob_id [`BRB_LANES];
    logic [`BRB_LANES-1:0]           is_jalr;
    logic                            buffer_empty;
    logic                            buffer_full;
    count_t                          buffer_count;
    // Model view used to steer the stimulus
    logic [(1 << `BRB_ROB_ID_W)-1:0] id_busy;
    rob_id_t                         live_ids [`BRB_DEPTH];
    int                              live_num;
    int                              errors;
    int                              checks;
    int                              mark;
    int                              seed_ret;

    branch_resolution_buffer i_dut (.*);

    brb_scoreboard i_sb (.*);

    bind branch_resolution_buffer brb_chk i_chk (
        .clk, .rst_n, .resolved, .mispredicted, .buffer_empty, .buffer_full, .buffer_count
    );

    always #10 clk = ~clk;

    // ==================================================
    // Stimulus
    // ==================================================

    // One cycle of random traffic, new tags never collide with entries in flight
    task automatic drive_cycle(input int push_pct, input int exec_pct, input int mis_pct,
                               input int flush_pct, input bit oldest);
        logic [(1 << `BRB_ROB_ID_W)-1:0] taken;
        rob_id_t                         id;
        int                              pick;
        @(posedge clk);
        taken = id_busy;
        for (int l = 0; l < `BRB_LANES; l++) begin
            do begin
                id = rob_id_t'($urandom);
            end while (taken[id]);
            taken[id] = 1'b1;
            push_en[l]      <= (int'($urandom % 100) < push_pct);
            push_rob_id[l]  <= id;
            push_is_jalr[l] <= 1'($urandom);
            // Lane 0 aims at the oldest pending branch for the bypass case
            pick = 0;
            if (live_num > 0 && !(oldest && l == 0)) begin
                pick = int'($urandom % live_num);
            end
            exec_valid[l]        <= (live_num > 0) && (int'($urandom % 100) < exec_pct);
            exec_rob_id[l]       <= live_ids[pick];
            exec_mispredicted[l] <= (int'($urandom % 100) < mis_pct);
            exec_correct_pc[l]   <= $urandom;
        end
        flush_en <= (int'($urandom % 100) < flush_pct);
    endtask

    // Runs one test and reports its error count
    task automatic run_test(input int num, input string name, input int cycles,
                            input int push_pct, input int exec_pct, input int mis_pct,
                            input int flush_pct, input bit oldest);
        repeat (cycles) drive_cycle(push_pct, exec_pct, mis_pct, flush_pct, oldest);
        // Let the last cycle be compared
        @(negedge clk);
        #1;
        $display("Test %0d %s: %0d errors", num, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        seed_ret     = $urandom(SEED);
        mark         = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        push_en      = '0;
        push_is_jalr = '0;
        exec_valid   = '0;
        exec_mispredicted = '0;
        flush_en     = 1'b0;
        for (int l = 0; l < `BRB_LANES; l++) begin
            push_rob_id[l]     = '0;
            exec_rob_id[l]     = '0;
            exec_correct_pc[l] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_test(1, "reset", SETTLE_CYCLES, 0, 0, 0, 0, 1'b0);
        run_test(2, "in-order resolution", TEST_CYCLES, 40, 60, 0, 0, 1'b0);
        run_test(3, "bypass", TEST_CYCLES, 30, 50, 0, 0, 1'b1);
        run_test(4, "mispredict flush", TEST_CYCLES, 50, 60, 10, 0, 1'b0);
        run_test(5, "overflow drop", TEST_CYCLES, 95, 15, 0, 0, 1'b0);
        run_test(6, "external flush", TEST_CYCLES, 50, 60, 0, 8, 1'b0);
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.i_chk.failures);
        if (errors == 0 && i_dut.i_chk.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* branch_resolution_buffer.f */
+incdir+verilog
verilog/brb_tag_pkg.sv
verilog/brb_ptr_pkg.sv
verilog/brb_alloc.sv
verilog/brb_slot.sv
verilog/brb_resolve.sv
verilog/branch_resolution_buffer.sv
verification/brb_chk.sv
verification/brb_scoreboard.sv
verification/tb_branch_resolution_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the branch resolution buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_branch_resolution_buffer \
    -f branch_resolution_buffer.f -o sim_brb
status=0
./obj_dir/sim_brb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failures"
